//--- convAccelTop.f
hdl/convAccelPkg.sv
hdl/convLoopCtrl.sv
hdl/operandAddrGen.sv
hdl/bankedOperandMem.sv
hdl/macUnit.sv
hdl/outFifo.sv
hdl/convAccelTop.sv
tb/convAccelTb.sv

//--- Bender.yml
package:
  name: convAccel

sources:
  - hdl/convAccelPkg.sv
  - hdl/convLoopCtrl.sv
  - hdl/operandAddrGen.sv
  - hdl/bankedOperandMem.sv
  - hdl/macUnit.sv
  - hdl/outFifo.sv
  - hdl/convAccelTop.sv
  - target: test
    files:
      - tb/convAccelTb.sv

//--- tb/convAccelTb.sv
`timescale 1ns/1ps

module convAccelTb;
    import convAccelPkg::*;

    localparam int numTests = 5;

    // Test table, one column per array
    int    tFiltRows [numTests] = '{3, 2, 2, 3, 3};
    int    tFiltCols [numTests] = '{3, 5, 7, 4, 4};
    int    tDataRows [numTests] = '{6, 9, 8, 7, 7};
    int    tDataCols [numTests] = '{6, 12, 16, 7, 7};
    bit    tRandReady [numTests] = '{0, 0, 1, 0, 0};
    bit    tNewData [numTests] = '{1, 1, 1, 1, 0};
    bit    tPartial [numTests] = '{0, 0, 0, 0, 1};
    string tName [numTests] = '{"filt3x3Data6x6", "filt2x5Data9x12", "randomReady",
                                "backToBackFirst", "backToBackPartial"};

    logic                clkIn;
    logic                rstIn;
    logic                startIn;
    convCfgT             cfgIn;
    logic                wrValidIn;
    busWriteT            busWrIn;
    logic                readyIn;
    logic                validOut;
    logic [accWidth-1:0] dataOut;
    logic                busyOut;

    // Model copies of both operand memories
    int          dataMat [maxElems];
    int          filtMat [maxElems];
    int          expQ [$];
    logic [31:0] rngState = 32'h18c8;
    int          errorCount = 0;
    int          passCount = 0;
    int          failCount = 0;
    int          cycleCount = 0;

    convAccelTop UUT (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .startIn  (startIn),
        .cfgIn    (cfgIn),
        .wrValidIn(wrValidIn),
        .busWrIn  (busWrIn),
        .readyIn  (readyIn),
        .validOut (validOut),
        .dataOut  (dataOut),
        .busyOut  (busyOut)
    );

    initial begin
        clkIn = 1'b0;
        forever #2 clkIn = ~clkIn;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // Range -128..127 keeps the sums readable
    function automatic int smallOperand();
        logic [31:0] rnd;
        rnd = nextRand();
        return int'($signed(rnd[7:0]));
    endfunction

    function automatic int cycleLimit();
        int total;
        int outputs;
        int chunks;
        total = 2000;
        for (int t = 0; t < numTests; t++) begin
            outputs = (tDataRows[t] - tFiltRows[t] + 1) * (tDataCols[t] - tFiltCols[t] + 1);
            chunks  = (tFiltCols[t] + laneCount - 1) / laneCount;
            total  += outputs * chunks * tFiltRows[t] * 4;
        end
        return total;
    endfunction

    task automatic checkBit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERROR %0t %s expected %b got %b", $time, name, exp, got);
            errorCount++;
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t %s expected %0d got %0d", $time, name, $signed(exp), $signed(got));
            errorCount++;
        end
    endtask

    task automatic writeLine(input logic sel, input int line, input logic [3:0] en,
                             input laneVecT vec);
        @(posedge clkIn);
        wrValidIn <= 1'b1;
        busWrIn   <= '{line: line[lineAddrWidth-1:0], sel: sel, elemEn: en, data: vec};
    endtask

    task automatic loadOperands(input int t);
        int                   dataLen;
        int                   filtLen;
        int                   val;
        laneVecT              vec;
        logic [laneCount-1:0] en;
        dataLen = tDataRows[t] * tDataCols[t];
        filtLen = tFiltRows[t] * tFiltCols[t];
        if (tNewData[t]) begin
            for (int a = 0; a < dataLen; a++) begin
                dataMat[a] = smallOperand();
            end
            for (int l = 0; l < (dataLen + laneCount - 1) / laneCount; l++) begin
                for (int k = 0; k < laneCount; k++) begin
                    vec[k] = 16'(dataMat[laneCount * l + k]);
                end
                writeLine(1'b0, l, 4'b1111, vec);
            end
        end
        // Disabled lanes carry new values that must not land
        for (int l = 0; l < (filtLen + laneCount - 1) / laneCount; l++) begin
            en = tPartial[t] ? (l[0] ? 4'b0110 : 4'b1101) : 4'b1111;
            for (int k = 0; k < laneCount; k++) begin
                val    = smallOperand();
                vec[k] = 16'(val);
                if (en[k]) begin
                    filtMat[laneCount * l + k] = val;
                end
            end
            writeLine(1'b1, l, en, vec);
        end
        @(posedge clkIn);
        wrValidIn <= 1'b0;
    endtask

    // Reference sums, row-major, 32-bit wrap
    task automatic buildExpected(input int t);
        int acc;
        expQ.delete();
        for (int r = 0; r <= tDataRows[t] - tFiltRows[t]; r++) begin
            for (int c = 0; c <= tDataCols[t] - tFiltCols[t]; c++) begin
                acc = 0;
                for (int i = 0; i < tFiltRows[t]; i++) begin
                    for (int j = 0; j < tFiltCols[t]; j++) begin
                        acc += dataMat[(r + i) * tDataCols[t] + c + j] *
                               filtMat[i * tFiltCols[t] + j];
                    end
                end
                expQ.push_back(acc);
            end
        end
    endtask

    task automatic runTest(input int t);
        int          errorsBefore;
        int          expCount;
        int          gotCount;
        int          expVal;
        logic [31:0] rnd;
        errorsBefore = errorCount;
        loadOperands(t);
        buildExpected(t);
        expCount = expQ.size();
        gotCount = 0;
        @(posedge clkIn);
        cfgIn   <= '{filtRows: dimWidth'(tFiltRows[t]), filtCols: dimWidth'(tFiltCols[t]),
                     dataRows: dimWidth'(tDataRows[t]), dataCols: dimWidth'(tDataCols[t])};
        startIn <= 1'b1;
        @(posedge clkIn);
        startIn <= 1'b0;
        // Start was sampled on this edge
        @(negedge clkIn);
        checkBit("busyOut", busyOut, 1'b1);
        while (gotCount < expCount) begin
            // Handshake seen here completes on the next rising edge
            @(negedge clkIn);
            if (validOut && readyIn) begin
                expVal = expQ.pop_front();
                checkWord("dataOut", dataOut, expVal);
                gotCount++;
            end
            @(posedge clkIn);
            rnd = nextRand();
            // Ready about one cycle in eight, so the FIFO fills and stalls the loops
            readyIn <= tRandReady[t] ? (rnd[0] & rnd[1] & rnd[2]) : 1'b1;
        end
        @(posedge clkIn);
        readyIn <= 1'b1;
        // Nothing may follow the final result
        repeat (16) begin
            @(negedge clkIn);
            checkBit("validOut", validOut, 1'b0);
            checkBit("busyOut", busyOut, 1'b0);
        end
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("Test %0d %s: %0d results, ok", t, tName[t], gotCount);
        end else begin
            failCount++;
            $display("Test %0d %s: %0d results, %0d errors", t, tName[t], gotCount,
                     errorCount - errorsBefore);
        end
    endtask

    initial begin
        int limit;
        limit = cycleLimit();
        while (cycleCount <= limit) begin
            @(posedge clkIn);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rstIn     = 1'b1;
        startIn   = 1'b0;
        cfgIn     = '0;
        wrValidIn = 1'b0;
        busWrIn   = '0;
        readyIn   = 1'b1;
        repeat (16) @(posedge clkIn);
        rstIn <= 1'b0;
        // Idle after reset
        repeat (8) begin
            @(negedge clkIn);
            checkBit("validOut", validOut, 1'b0);
            checkBit("busyOut", busyOut, 1'b0);
        end
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("Tests ok %0d, tests with errors %0d, errors %0d", passCount, failCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/convAccelTop.sv
`timescale 1ns/1ps

module convAccelTop (
    input  logic                                 clkIn,
    input  logic                                 rstIn,
    input  logic                                 startIn,
    input  convAccelPkg::convCfgT                cfgIn,
    input  logic                                 wrValidIn,
    input  convAccelPkg::busWriteT               busWrIn,
    input  logic                                 readyIn,
    output logic                                 validOut,
    output logic [convAccelPkg::accWidth-1:0]    dataOut,
    output logic                                 busyOut
);
    import convAccelPkg::*;

    // Loop step from the controller
    logic                 stepValid;
    logic                 stepLast;
    logic [dimWidth-1:0]  dataRowIdx;
    logic [dimWidth-1:0]  dataColIdx;
    logic [dimWidth-1:0]  filtRowIdx;
    logic [dimWidth-1:0]  filtColIdx;
    logic [laneCount-1:0] laneMask;
    convCfgT              latchedCfg;

    readReqT dataReq;
    readReqT filtReq;

    // Aligned operands
    laneVecT dataVec;
    laneVecT filtVec;
    logic    dataRdValid;
    logic    dataRdLast;
    opPairT  opPair;

    logic                resValid;
    logic [accWidth-1:0] resData;
    logic                fifoWrReady;

    convLoopCtrl loopCtrl (
        .clkIn      (clkIn),
        .rstIn      (rstIn),
        .startIn    (startIn),
        .cfgIn      (cfgIn),
        .fifoWrReady(fifoWrReady),
        .busyOut    (busyOut),
        .stepValid  (stepValid),
        .stepLast   (stepLast),
        .dataRowIdx (dataRowIdx),
        .dataColIdx (dataColIdx),
        .filtRowIdx (filtRowIdx),
        .filtColIdx (filtColIdx),
        .laneMask   (laneMask),
        .latchedCfg (latchedCfg)
    );

    operandAddrGen addrGen (
        .clkIn     (clkIn),
        .rstIn     (rstIn),
        .stepValid (stepValid),
        .stepLast  (stepLast),
        .dataRowIdx(dataRowIdx),
        .dataColIdx(dataColIdx),
        .filtRowIdx(filtRowIdx),
        .filtColIdx(filtColIdx),
        .laneMask  (laneMask),
        .latchedCfg(latchedCfg),
        .dataReq   (dataReq),
        .filtReq   (filtReq)
    );

    bankedOperandMem #(.memSel(1'b0)) dataMem (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .wrValidIn(wrValidIn),
        .busWrIn  (busWrIn),
        .readReq  (dataReq),
        .rdVec    (dataVec),
        .rdValid  (dataRdValid),
        .rdLast   (dataRdLast)
    );

    // Runs in lockstep with the data side, so its flags are not needed
    bankedOperandMem #(.memSel(1'b1)) filtMem (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .wrValidIn(wrValidIn),
        .busWrIn  (busWrIn),
        .readReq  (filtReq),
        .rdVec    (filtVec),
        .rdValid  (),
        .rdLast   ()
    );

    assign opPair = '{valid: dataRdValid, last: dataRdLast, dataVec: dataVec, filtVec: filtVec};

    macUnit mac (
        .clkIn   (clkIn),
        .rstIn   (rstIn),
        .ops     (opPair),
        .resValid(resValid),
        .resData (resData)
    );

    outFifo resFifo (
        .clkIn   (clkIn),
        .rstIn   (rstIn),
        .wrValid (resValid),
        .wrData  (resData),
        .readyIn (readyIn),
        .wrReady (fifoWrReady),
        .validOut(validOut),
        .dataOut (dataOut)
    );

endmodule

//--- hdl/outFifo.sv
`timescale 1ns/1ps

module outFifo (
    input  logic                                 clkIn,
    input  logic                                 rstIn,
    input  logic                                 wrValid,
    input  logic [convAccelPkg::accWidth-1:0]    wrData,
    input  logic                                 readyIn,
    output logic                                 wrReady,
    output logic                                 validOut,
    output logic [convAccelPkg::accWidth-1:0]    dataOut
);
    import convAccelPkg::*;

    logic [accWidth-1:0]          mem [fifoDepth];
    logic [$clog2(fifoDepth)-1:0] wrPtr;
    logic [$clog2(fifoDepth)-1:0] rdPtr;
    logic [$clog2(fifoDepth):0]   count;
    logic                         push;
    logic                         pop;

    assign push = wrValid && (count != fifoDepth);
    assign pop  = validOut && readyIn;

    always_ff @(posedge clkIn) begin
        if (push) begin
            mem[wrPtr] <= wrData;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign validOut = (count != '0);
    assign dataOut  = mem[rdPtr];

    // Free entries left over cover the results still in the pipeline
    assign wrReady = (fifoDepth - count) >= fifoSkid;

endmodule

//--- hdl/macUnit.sv
`timescale 1ns/1ps

module macUnit (
    input  logic                                 clkIn,
    input  logic                                 rstIn,
    input  convAccelPkg::opPairT                 ops,
    output logic                                 resValid,
    output logic [convAccelPkg::accWidth-1:0]    resData
);
    import convAccelPkg::*;

    logic signed [accWidth-1:0] prod [laneCount];
    logic                       p1Valid;
    logic                       p1Last;
    logic signed [accWidth-1:0] acc;
    logic signed [accWidth-1:0] sum;

    // Lane multipliers; masked lanes arrive as zero
    always_ff @(posedge clkIn) begin
        for (int k = 0; k < laneCount; k++) begin
            prod[k] <= $signed(ops.dataVec[k]) * $signed(ops.filtVec[k]);
        end
        p1Last <= ops.last;
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            p1Valid <= 1'b0;
        end else begin
            p1Valid <= ops.valid;
        end
    end

    // Adder tree plus running sum, wraps on overflow
    always_comb begin
        sum = acc;
        for (int k = 0; k < laneCount; k++) begin
            sum = sum + prod[k];
        end
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            acc <= '0;
        end else if (p1Valid) begin
            acc <= p1Last ? '0 : sum;
        end
    end

    // Written into the FIFO on the same edge that clears acc
    assign resValid = p1Valid && p1Last;
    assign resData  = sum;

endmodule

//--- hdl/bankedOperandMem.sv
`timescale 1ns/1ps

module bankedOperandMem #(
    parameter logic memSel = 1'b0
) (
    input  logic                     clkIn,
    input  logic                     rstIn,
    input  logic                     wrValidIn,
    input  convAccelPkg::busWriteT   busWrIn,
    input  convAccelPkg::readReqT    readReq,
    output convAccelPkg::laneVecT    rdVec,
    output logic                     rdValid,
    output logic                     rdLast
);
    import convAccelPkg::*;

    // Registered bus write
    logic [laneCount-1:0]     wrEn;
    logic [lineAddrWidth-1:0] wrLine;
    laneVecT                  wrData;

    // Read stage one
    laneVecT                 bankOut;
    logic                    s1Valid;
    logic                    s1Last;
    logic [laneCount-1:0]    s1Mask;
    logic [laneIdxWidth-1:0] s1Off;
    laneVecT                 alignVec;

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            wrEn <= '0;
        end else begin
            wrEn <= (wrValidIn && busWrIn.sel == memSel) ? busWrIn.elemEn : '0;
        end
    end

    always_ff @(posedge clkIn) begin
        wrLine <= busWrIn.line;
        wrData <= busWrIn.data;
    end

    for (genvar k = 0; k < laneCount; k++) begin : gBank
        logic [elemWidth-1:0]     mem [bankDepth];
        logic [elemWidth-1:0]     rdWord;
        logic [laneIdxWidth-1:0]  rot;
        logic [elemAddrWidth-1:0] addr;

        // First element at or after elemAddr that lives in this bank
        assign rot  = laneIdxWidth'(k) - readReq.elemAddr[laneIdxWidth-1:0];
        assign addr = readReq.elemAddr + elemAddrWidth'(rot);

        always_ff @(posedge clkIn) begin
            if (wrEn[k]) begin
                mem[wrLine] <= wrData[k];
            end
            rdWord <= mem[addr[elemAddrWidth-1:laneIdxWidth]];
        end

        assign bankOut[k] = rdWord;
    end

    always_ff @(posedge clkIn) begin
        s1Mask <= readReq.laneMask;
        s1Off  <= readReq.elemAddr[laneIdxWidth-1:0];
        s1Last <= readReq.last;
    end

    // Lane j takes element elemAddr + j
    always_comb begin
        logic [laneIdxWidth-1:0] srcLane;
        for (int j = 0; j < laneCount; j++) begin
            srcLane     = laneIdxWidth'(j) + s1Off;
            alignVec[j] = s1Mask[j] ? bankOut[srcLane] : '0;
        end
    end

    always_ff @(posedge clkIn) begin
        rdVec  <= alignVec;
        rdLast <= s1Last;
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            s1Valid <= 1'b0;
            rdValid <= 1'b0;
        end else begin
            s1Valid <= readReq.valid;
            rdValid <= s1Valid;
        end
    end

endmodule

//--- hdl/operandAddrGen.sv
`timescale 1ns/1ps

module operandAddrGen (
    input  logic                                 clkIn,
    input  logic                                 rstIn,
    input  logic                                 stepValid,
    input  logic                                 stepLast,
    input  logic [convAccelPkg::dimWidth-1:0]    dataRowIdx,
    input  logic [convAccelPkg::dimWidth-1:0]    dataColIdx,
    input  logic [convAccelPkg::dimWidth-1:0]    filtRowIdx,
    input  logic [convAccelPkg::dimWidth-1:0]    filtColIdx,
    input  logic [convAccelPkg::laneCount-1:0]   laneMask,
    input  convAccelPkg::convCfgT                latchedCfg,
    output convAccelPkg::readReqT                dataReq,
    output convAccelPkg::readReqT                filtReq
);
    import convAccelPkg::*;

    logic                     s1Valid;
    logic                     s1Last;
    logic [laneCount-1:0]     s1Mask;
    logic [elemAddrWidth-1:0] s1DataBase;
    logic [elemAddrWidth-1:0] s1FiltBase;
    logic [elemAddrWidth-1:0] s1DataCol;
    logic [elemAddrWidth-1:0] s1FiltCol;

    // Row products; addresses wrap at the memory size
    always_ff @(posedge clkIn) begin
        s1Mask     <= laneMask;
        s1Last     <= stepLast;
        s1DataBase <= elemAddrWidth'((dataRowIdx + filtRowIdx) * latchedCfg.dataCols);
        s1FiltBase <= elemAddrWidth'(filtRowIdx * latchedCfg.filtCols);
        s1DataCol  <= elemAddrWidth'(dataColIdx + filtColIdx);
        s1FiltCol  <= elemAddrWidth'(filtColIdx);
    end

    // Column offsets
    always_ff @(posedge clkIn) begin
        dataReq.last     <= s1Last;
        dataReq.laneMask <= s1Mask;
        dataReq.elemAddr <= s1DataBase + s1DataCol;
        filtReq.last     <= s1Last;
        filtReq.laneMask <= s1Mask;
        filtReq.elemAddr <= s1FiltBase + s1FiltCol;
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            s1Valid       <= 1'b0;
            dataReq.valid <= 1'b0;
            filtReq.valid <= 1'b0;
        end else begin
            s1Valid       <= stepValid;
            dataReq.valid <= s1Valid;
            filtReq.valid <= s1Valid;
        end
    end

endmodule

//--- hdl/convLoopCtrl.sv
`timescale 1ns/1ps

module convLoopCtrl (
    input  logic                                 clkIn,
    input  logic                                 rstIn,
    input  logic                                 startIn,
    input  convAccelPkg::convCfgT                cfgIn,
    input  logic                                 fifoWrReady,
    output logic                                 busyOut,
    output logic                                 stepValid,
    output logic                                 stepLast,
    output logic [convAccelPkg::dimWidth-1:0]    dataRowIdx,
    output logic [convAccelPkg::dimWidth-1:0]    dataColIdx,
    output logic [convAccelPkg::dimWidth-1:0]    filtRowIdx,
    output logic [convAccelPkg::dimWidth-1:0]    filtColIdx,
    output logic [convAccelPkg::laneCount-1:0]   laneMask,
    output convAccelPkg::convCfgT                latchedCfg
);
    import convAccelPkg::*;

    typedef enum logic {idleSt, runSt} stateT;

    stateT state;
    logic  startAccept;

    // End values, latched at start
    logic [dimWidth-1:0] filtColEnd;
    logic [dimWidth-1:0] filtRowEnd;
    logic [dimWidth-1:0] dataColEnd;
    logic [dimWidth-1:0] dataRowEnd;
    logic [dimWidth-1:0] lastFiltCol;

    logic filtColDone;
    logic filtRowDone;
    logic dataColDone;
    logic dataRowDone;

    assign startAccept = (state == idleSt) && startIn;
    assign lastFiltCol = cfgIn.filtCols - 1'b1;

    // Column end is the start of the final chunk
    always_ff @(posedge clkIn) begin
        if (startAccept) begin
            latchedCfg <= cfgIn;
            filtColEnd <= {lastFiltCol[dimWidth-1:laneIdxWidth], {laneIdxWidth{1'b0}}};
            filtRowEnd <= cfgIn.filtRows - 1'b1;
            dataColEnd <= cfgIn.dataCols - cfgIn.filtCols;
            dataRowEnd <= cfgIn.dataRows - cfgIn.filtRows;
        end
    end

    assign filtColDone = (filtColIdx == filtColEnd);
    assign filtRowDone = (filtRowIdx == filtRowEnd);
    assign dataColDone = (dataColIdx == dataColEnd);
    assign dataRowDone = (dataRowIdx == dataRowEnd);

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            state      <= idleSt;
            filtColIdx <= '0;
            filtRowIdx <= '0;
            dataColIdx <= '0;
            dataRowIdx <= '0;
        end else begin
            case (state)
                idleSt: begin
                    if (startAccept) begin
                        state      <= runSt;
                        filtColIdx <= '0;
                        filtRowIdx <= '0;
                        dataColIdx <= '0;
                        dataRowIdx <= '0;
                    end
                end
                runSt: begin
                    // Innermost first; everything holds under back-pressure
                    if (fifoWrReady) begin
                        if (!filtColDone) begin
                            filtColIdx <= filtColIdx + dimWidth'(laneCount);
                        end else begin
                            filtColIdx <= '0;
                            if (!filtRowDone) begin
                                filtRowIdx <= filtRowIdx + 1'b1;
                            end else begin
                                filtRowIdx <= '0;
                                if (!dataColDone) begin
                                    dataColIdx <= dataColIdx + 1'b1;
                                end else begin
                                    dataColIdx <= '0;
                                    if (!dataRowDone) begin
                                        dataRowIdx <= dataRowIdx + 1'b1;
                                    end else begin
                                        state <= idleSt;
                                    end
                                end
                            end
                        end
                    end
                end
                default: state <= idleSt;
            endcase
        end
    end

    assign busyOut   = (state == runSt);
    assign stepValid = busyOut && fifoWrReady;
    assign stepLast  = filtColDone && filtRowDone;

    // Only the final chunk of a row has lanes past the filter edge
    always_comb begin
        for (int k = 0; k < laneCount; k++) begin
            laneMask[k] = (filtColIdx + dimWidth'(k)) < latchedCfg.filtCols;
        end
    end

endmodule

//--- hdl/convAccelPkg.sv
package convAccelPkg;

    // Vector and operand sizes
    localparam int laneCount     = 4;
    localparam int laneIdxWidth  = 2;
    localparam int elemWidth     = 16;
    localparam int accWidth      = 32;

    // Operand memory geometry
    localparam int maxElems      = 1024;
    localparam int bankDepth     = maxElems / laneCount;
    localparam int lineAddrWidth = 8;
    localparam int elemAddrWidth = 10;

    // Matrix dimensions up to and including 1024
    localparam int dimWidth      = 11;

    // Top bit picks the filter memory, the rest is the line
    localparam int busAddrWidth  = 9;

    // Output buffering
    localparam int fifoDepth     = 16;
    localparam int fifoSkid      = 8;

    typedef struct packed {
        logic [dimWidth-1:0] filtRows;
        logic [dimWidth-1:0] filtCols;
        logic [dimWidth-1:0] dataRows;
        logic [dimWidth-1:0] dataCols;
    } convCfgT;

    // Lane 0 sits in the low bits
    typedef logic [laneCount-1:0][elemWidth-1:0] laneVecT;

    typedef struct packed {
        logic [busAddrWidth-2:0] line;
        logic                    sel;
        logic [laneCount-1:0]    elemEn;
        laneVecT                 data;
    } busWriteT;

    typedef struct packed {
        logic                     valid;
        logic                     last;
        logic [elemAddrWidth-1:0] elemAddr;
        logic [laneCount-1:0]     laneMask;
    } readReqT;

    typedef struct packed {
        logic    valid;
        logic    last;
        laneVecT dataVec;
        laneVecT filtVec;
    } opPairT;

endpackage
